//--- verilog/dist_settings.svh
`ifndef DIST_SETTINGS_SVH
`define DIST_SETTINGS_SVH

// width of one payload word
`define DIST_DATA_WIDTH 25

// processing-element ports on the chain
`define DIST_NUM_NODE 16

// node index width, log2 of the node count
`define DIST_DEST_WIDTH 4

`endif

//--- verilog/dist_flit_pkg.sv
`include "dist_settings.svh"

////////////////////////////////////////////////////////////////////////////
// flit-side types shared by ingress, chain and top
////////////////////////////////////////////////////////////////////////////

package dist_flit_pkg;

	// one payload word carried by a flit
	typedef logic [`DIST_DATA_WIDTH-1:0] data_t;

	// destination tag, index of a node
	typedef logic [`DIST_DEST_WIDTH-1:0] dest_t;

	// one bit per node, bit d selects node d
	// also the shape of the per-node valid vector
	typedef logic [`DIST_NUM_NODE-1:0] mask_t;

endpackage

//--- verilog/dist_ctrl_pkg.sv
`include "dist_settings.svh"

////////////////////////////////////////////////////////////////////////////
// control encodings of the host side and the ingress FSM
////////////////////////////////////////////////////////////////////////////

package dist_ctrl_pkg;

	// host command
	typedef enum logic [1:0] {
		OP_NOP       = 2'd0,
		OP_UNICAST   = 2'd1,
		OP_MULTICAST = 2'd2
	} opcode_t;

	// ingress sequencer
	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_WALK = 1'b1
	} ingress_state_t;

endpackage

//--- verilog/dist_ingress.sv
////////////////////////////////////////////////////////////////////////////
// ingress sequencer
// turns host commands into destination-tagged flits for the chain
////////////////////////////////////////////////////////////////////////////

module dist_ingress (
	input  logic                   CLK,
	input  logic                   i_rst_n,
	input  logic                   i_en,
	input  logic                   i_cmd_valid,
	input  dist_ctrl_pkg::opcode_t i_opcode,
	input  dist_flit_pkg::data_t   i_data,
	input  dist_flit_pkg::dest_t   i_dest,
	input  dist_flit_pkg::mask_t   i_mask,
	output logic                   o_busy,
	output logic                   o_flit_valid,
	output dist_flit_pkg::data_t   o_flit_data,
	output dist_flit_pkg::dest_t   o_flit_dest
);

	// FSM and walk state
	dist_ctrl_pkg::ingress_state_t state_q;
	dist_flit_pkg::mask_t          rem_mask_q;
	dist_flit_pkg::mask_t          rem_next;
	dist_flit_pkg::dest_t          low_idx;

	// staged unicast, one cycle ahead of the flit register
	logic                          uni_pend_q;
	dist_flit_pkg::dest_t          uni_dest_q;

	// word of the current command
	dist_flit_pkg::data_t          data_q;

	// command decode
	logic                          accept;
	logic                          uni_go;
	logic                          mc_go;

	// next flit
	logic                          flit_valid_d;
	dist_flit_pkg::dest_t          flit_dest_d;

	assign o_busy = (state_q == dist_ctrl_pkg::ST_WALK);

	// busy blocks new commands, so does a disabled network
	assign accept = i_cmd_valid && i_en && !o_busy;
	assign uni_go = accept && (i_opcode == dist_ctrl_pkg::OP_UNICAST);
	// empty mask sends nothing, stays idle
	assign mc_go  = accept && (i_opcode == dist_ctrl_pkg::OP_MULTICAST) && (|i_mask);

	////////////////////////////////////////////////////////////////////////////
	// lowest set bit of the remaining mask
	////////////////////////////////////////////////////////////////////////////

	// priority encoder, scan downward so the lowest index wins
	always_comb
	begin
		low_idx = '0;
		for (int d = $bits(dist_flit_pkg::mask_t) - 1; d >= 0; d--)
		begin
			if (rem_mask_q[d])
				low_idx = dist_flit_pkg::dest_t'(d);
		end
	end

	// drop the lowest set bit
	assign rem_next = rem_mask_q & (rem_mask_q - dist_flit_pkg::mask_t'(1));

	// walk and staged unicast never overlap
	assign flit_valid_d = o_busy || uni_pend_q;
	assign flit_dest_d  = o_busy ? low_idx : (uni_pend_q ? uni_dest_q : '0);

	////////////////////////////////////////////////////////////////////////////
	// control and flit registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state_q      <= dist_ctrl_pkg::ST_IDLE;
			rem_mask_q   <= '0;
			uni_pend_q   <= 1'b0;
			o_flit_valid <= 1'b0;
			o_flit_data  <= '0;
			o_flit_dest  <= '0;
		end
		else if (!i_en)
		begin
			// walk pauses with state and mask held
			// a staged unicast counts as in flight and is dropped
			uni_pend_q   <= 1'b0;
			o_flit_valid <= 1'b0;
			o_flit_data  <= '0;
			o_flit_dest  <= '0;
		end
		else
		begin
			uni_pend_q   <= uni_go;
			o_flit_valid <= flit_valid_d;
			// dummy data is zero
			o_flit_data  <= flit_valid_d ? data_q : '0;
			o_flit_dest  <= flit_dest_d;

			case (state_q)
				dist_ctrl_pkg::ST_IDLE:
				begin
					if (mc_go)
					begin
						rem_mask_q <= i_mask;
						state_q    <= dist_ctrl_pkg::ST_WALK;
					end
				end
				dist_ctrl_pkg::ST_WALK:
				begin
					rem_mask_q <= rem_next;
					// last flit goes out on this edge
					if (rem_next == '0)
						state_q <= dist_ctrl_pkg::ST_IDLE;
				end
				default:
				begin
					state_q <= dist_ctrl_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// payload latch, taken on every accepted command that sends something
	always_ff @(posedge CLK)
	begin
		if (uni_go || mc_go)
		begin
			data_q     <= i_data;
			uni_dest_q <= i_dest;
		end
	end

endmodule

//--- verilog/dist_node_stage.sv
////////////////////////////////////////////////////////////////////////////
// one stage of the linear chain
// tag match onto the local port, forward to the next stage
////////////////////////////////////////////////////////////////////////////

module dist_node_stage #(
	parameter int unsigned NODE_INDEX = 0
) (
	input  logic                 CLK,
	input  logic                 i_rst_n,
	input  logic                 i_en,
	input  logic                 i_valid,
	input  dist_flit_pkg::data_t i_data,
	input  dist_flit_pkg::dest_t i_dest,
	output logic                 o_valid,
	output dist_flit_pkg::data_t o_data,
	output dist_flit_pkg::dest_t o_dest,
	output logic                 o_node_valid,
	output dist_flit_pkg::data_t o_node_data
);

	// flit is for this node
	logic hit;

	assign hit = i_valid && (i_dest == dist_flit_pkg::dest_t'(NODE_INDEX));

	////////////////////////////////////////////////////////////////////////////
	// forward register, feeds stage NODE_INDEX+1
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_valid <= 1'b0;
			o_data  <= '0;
			o_dest  <= '0;
		end
		else if (!i_en)
		begin
			// disabled, flits in flight are dropped
			o_valid <= 1'b0;
			o_data  <= '0;
			o_dest  <= '0;
		end
		else
		begin
			// every flit moves on, matched or not
			o_valid <= i_valid;
			o_data  <= i_data;
			o_dest  <= i_dest;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// port register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_node_valid <= 1'b0;
			o_node_data  <= '0;
		end
		else if (!i_en || !hit)
		begin
			// port idles at zero
			o_node_valid <= 1'b0;
			o_node_data  <= '0;
		end
		else
		begin
			o_node_valid <= 1'b1;
			o_node_data  <= i_data;
		end
	end

endmodule

//--- verilog/linear_unicast_chain.sv
`include "dist_settings.svh"

////////////////////////////////////////////////////////////////////////////
// linear chain of node stages
// node d sees a flit d cycles after node 0
////////////////////////////////////////////////////////////////////////////

module linear_unicast_chain (
	input  logic                                        CLK,
	input  logic                                        i_rst_n,
	input  logic                                        i_en,
	input  logic                                        i_valid,
	input  dist_flit_pkg::data_t                        i_data,
	input  dist_flit_pkg::dest_t                        i_dest,
	output dist_flit_pkg::mask_t                        o_node_valid,
	// node d on slice [d*DIST_DATA_WIDTH +: DIST_DATA_WIDTH]
	output logic [`DIST_NUM_NODE*`DIST_DATA_WIDTH-1:0]  o_node_data
);

	// stage k forward outputs, read by stage k+1
	logic                 fwd_valid [0:`DIST_NUM_NODE-2];
	dist_flit_pkg::data_t fwd_data  [0:`DIST_NUM_NODE-2];
	dist_flit_pkg::dest_t fwd_dest  [0:`DIST_NUM_NODE-2];

	for (genvar k = 0; k < `DIST_NUM_NODE; k++)
	begin : g_node
		logic                 in_valid;
		dist_flit_pkg::data_t in_data;
		dist_flit_pkg::dest_t in_dest;

		// head stage takes the chain inputs
		if (k == 0)
		begin : g_head
			assign in_valid = i_valid;
			assign in_data  = i_data;
			assign in_dest  = i_dest;
		end
		else
		begin : g_link
			assign in_valid = fwd_valid[k-1];
			assign in_data  = fwd_data[k-1];
			assign in_dest  = fwd_dest[k-1];
		end

		if (k < `DIST_NUM_NODE - 1)
		begin : g_mid
			dist_node_stage #(.NODE_INDEX(k)) u_stage (
				.CLK          (CLK),
				.i_rst_n      (i_rst_n),
				.i_en         (i_en),
				.i_valid      (in_valid),
				.i_data       (in_data),
				.i_dest       (in_dest),
				.o_valid      (fwd_valid[k]),
				.o_data       (fwd_data[k]),
				.o_dest       (fwd_dest[k]),
				.o_node_valid (o_node_valid[k]),
				.o_node_data  (o_node_data[k*`DIST_DATA_WIDTH +: `DIST_DATA_WIDTH])
			);
		end
		else
		begin : g_tail
			// end of the chain, nothing to forward to
			dist_node_stage #(.NODE_INDEX(k)) u_stage (
				.CLK          (CLK),
				.i_rst_n      (i_rst_n),
				.i_en         (i_en),
				.i_valid      (in_valid),
				.i_data       (in_data),
				.i_dest       (in_dest),
				.o_valid      (),
				.o_data       (),
				.o_dest       (),
				.o_node_valid (o_node_valid[k]),
				.o_node_data  (o_node_data[k*`DIST_DATA_WIDTH +: `DIST_DATA_WIDTH])
			);
		end
	end

endmodule

//--- verilog/dist_network_top.sv
////////////////////////////////////////////////////////////////////////////
// distribution network top
// host commands -> ingress sequencer -> linear chain -> PE ports
////////////////////////////////////////////////////////////////////////////

module dist_network_top (
	input  logic                   CLK,
	input  logic                   i_rst_n,
	// network enable level
	input  logic                   i_en,
	// host command, one-cycle strobe
	input  logic                   i_cmd_valid,
	input  dist_ctrl_pkg::opcode_t i_opcode,
	input  dist_flit_pkg::data_t   i_data,
	input  dist_flit_pkg::dest_t   i_dest,
	input  dist_flit_pkg::mask_t   i_mask,
	// high while a multicast is being walked
	output logic                   o_busy,
	// PE ports
	output dist_flit_pkg::mask_t   o_node_valid,
	output logic [$bits(dist_flit_pkg::mask_t)*$bits(dist_flit_pkg::data_t)-1:0] o_node_data
);

	// ingress to chain
	logic                 flit_valid;
	dist_flit_pkg::data_t flit_data;
	dist_flit_pkg::dest_t flit_dest;

	dist_ingress u_ingress (
		.CLK          (CLK),
		.i_rst_n      (i_rst_n),
		.i_en         (i_en),
		.i_cmd_valid  (i_cmd_valid),
		.i_opcode     (i_opcode),
		.i_data       (i_data),
		.i_dest       (i_dest),
		.i_mask       (i_mask),
		.o_busy       (o_busy),
		.o_flit_valid (flit_valid),
		.o_flit_data  (flit_data),
		.o_flit_dest  (flit_dest)
	);

	// one stage per PE
	linear_unicast_chain u_chain (
		.CLK          (CLK),
		.i_rst_n      (i_rst_n),
		.i_en         (i_en),
		.i_valid      (flit_valid),
		.i_data       (flit_data),
		.i_dest       (flit_dest),
		.o_node_valid (o_node_valid),
		.o_node_data  (o_node_data)
	);

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic CLK
);

	timeunit 1ns;
	timeprecision 1ps;

	// free-running, low at time zero
	initial
	begin
		CLK = 1'b0;
		forever
			#(PERIOD_NS / 2) CLK = ~CLK;
	end

endmodule

//--- tb/dist_network_sva.sv
`include "dist_settings.svh"

module dist_network_sva (
	input logic                                       CLK,
	input logic                                       i_rst_n,
	input logic                                       i_en,
	input logic                                       i_busy,
	input dist_flit_pkg::mask_t                       i_node_valid,
	input logic [`DIST_NUM_NODE*`DIST_DATA_WIDTH-1:0] i_node_data
);

	timeunit 1ns;
	timeprecision 1ps;

	// one sticky flag per property
	logic fail_one_port = 1'b0;
	logic fail_idle     = 1'b0;
	logic fail_busy     = 1'b0;
	logic fail_en_drop  = 1'b0;
	logic [3:0] fail_flags;

	// data bits of ports whose valid is low
	logic [`DIST_NUM_NODE*`DIST_DATA_WIDTH-1:0] idle_data;

	assign fail_flags = {fail_en_drop, fail_busy, fail_idle, fail_one_port};

	always_comb
	begin
		for (int d = 0; d < `DIST_NUM_NODE; d++)
			idle_data[d*`DIST_DATA_WIDTH +: `DIST_DATA_WIDTH] = i_node_valid[d] ? '0 :
				i_node_data[d*`DIST_DATA_WIDTH +: `DIST_DATA_WIDTH];
	end

	////////////////////////////////////////////////////////////////////////////
	// port properties
	////////////////////////////////////////////////////////////////////////////

	// node d at edge e and node d+1 at edge e+1 would be the same flit
	// so a flit never lands on two ports
	a_one_port : assert property (@(posedge CLK) disable iff (!i_rst_n)
		((($past(i_node_valid) << 1) & i_node_valid) == '0))
	else
	begin
		fail_one_port = 1'b1;
		$error("one flit delivered on two adjacent node ports");
	end

	// idle ports carry zero
	a_idle_zero : assert property (@(posedge CLK) disable iff (!i_rst_n) idle_data == '0)
	else
	begin
		fail_idle = 1'b1;
		$error("node data nonzero on a port with valid low");
	end

	// first edge out of reset
	a_busy_reset : assert property (@(posedge CLK) $rose(i_rst_n) |-> !i_busy)
	else
	begin
		fail_busy = 1'b1;
		$error("busy high right after reset");
	end

	// disabled edge empties every port
	a_en_drop : assert property (@(posedge CLK) disable iff (!i_rst_n)
		!i_en |=> i_node_valid == '0)
	else
	begin
		fail_en_drop = 1'b1;
		$error("node valid after an enable-low cycle");
	end

endmodule

bind dist_network_top dist_network_sva u_sva (
	.CLK          (CLK),
	.i_rst_n      (i_rst_n),
	.i_en         (i_en),
	.i_busy       (o_busy),
	.i_node_valid (o_node_valid),
	.i_node_data  (o_node_data)
);

//--- tb/dist_network_tb.sv
`include "dist_settings.svh"

module dist_network_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DW = `DIST_DATA_WIDTH;
	localparam int NN = `DIST_NUM_NODE;

	// phase lengths in cycles
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES  = 20;
	localparam int UNI_CYCLES   = 200;
	localparam int MC_CYCLES    = 400;
	localparam int MIX_CYCLES   = 300;
	localparam int NOP_CYCLES   = 60;
	localparam int DRAIN_CYCLES = 40;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_CYCLES + UNI_CYCLES + MC_CYCLES
		+ MIX_CYCLES + NOP_CYCLES + 4 * DRAIN_CYCLES + 40;

	logic                   CLK;
	logic                   rst_n;
	logic                   en;
	logic                   cmd_valid;
	dist_ctrl_pkg::opcode_t opcode;
	dist_flit_pkg::data_t   data;
	dist_flit_pkg::dest_t   dest;
	dist_flit_pkg::mask_t   mask;
	logic                   busy;
	dist_flit_pkg::mask_t   node_valid;
	logic [NN*DW-1:0]       node_data;

	integer seed;
	int     cycle_cnt = 0;
	// posedges since reset release
	int     edge_num;

	// reference model of the ingress walk
	logic                   m_busy;
	dist_flit_pkg::mask_t   m_rem;
	dist_flit_pkg::data_t   m_word;
	// pending deliveries per node as {due edge, word}
	logic [32+DW-1:0]       exp_q [NN][$];

	tb_clock_gen #(.PERIOD_NS(20)) u_clk (.CLK(CLK));

	dist_network_top dut (
		.CLK          (CLK),
		.i_rst_n      (rst_n),
		.i_en         (en),
		.i_cmd_valid  (cmd_valid),
		.i_opcode     (opcode),
		.i_data       (data),
		.i_dest       (dest),
		.i_mask       (mask),
		.o_busy       (busy),
		.o_node_valid (node_valid),
		.o_node_data  (node_data)
	);

	// hard stop past the longest legal run
	always @(posedge CLK)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("ERROR: run timed out after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// random helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int unsigned pick(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic dist_flit_pkg::data_t payload_word();
		return dist_flit_pkg::data_t'($random(seed));
	endfunction

	function automatic dist_flit_pkg::dest_t target_node();
		return dist_flit_pkg::dest_t'(pick(NN));
	endfunction

	// single bit, sparse, dense or full
	function automatic dist_flit_pkg::mask_t dest_mask();
		case (pick(4))
			0: return dist_flit_pkg::mask_t'(1) << pick(NN);
			1: return dist_flit_pkg::mask_t'($random(seed) & $random(seed));
			2: return dist_flit_pkg::mask_t'($random(seed));
			default: return '1;
		endcase
	endfunction

	function automatic int lowest_set(input dist_flit_pkg::mask_t m);
		for (int d = 0; d < NN; d++)
			if (m[d])
				return d;
		return 0;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// model and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("FAIL time %0t: %s expected 0x%0h actual 0x%0h",
				$time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "first mismatch, run stopped");
		end
	endtask

	// one rising edge with the inputs driven before it
	task automatic model_step();
		int due;
		int low;
		edge_num = edge_num + 1;
		if (!en)
		begin
			// everything in flight is lost while the walk holds
			for (int d = 0; d < NN; d++)
				exp_q[d].delete();
		end
		else if (m_busy)
		begin
			// flit sent now goes to the lowest node and lands d+1 later
			low = lowest_set(m_rem);
			due = edge_num + low + 1;
			exp_q[low].push_back({due, m_word});
			m_rem[low] = 1'b0;
			m_busy     = (m_rem != '0);
		end
		else if (cmd_valid && opcode == dist_ctrl_pkg::OP_UNICAST)
		begin
			// flit leaves one edge after acceptance
			due = edge_num + int'(dest) + 2;
			exp_q[dest].push_back({due, data});
		end
		else if (cmd_valid && opcode == dist_ctrl_pkg::OP_MULTICAST && mask != '0)
		begin
			m_busy = 1'b1;
			m_rem  = mask;
			m_word = data;
		end
	endtask

	task automatic compare_outputs();
		dist_flit_pkg::mask_t exp_valid;
		dist_flit_pkg::data_t exp_word [NN];
		logic [32+DW-1:0]     head;
		exp_valid = '0;
		for (int d = 0; d < NN; d++)
		begin
			exp_word[d] = '0;
			if (exp_q[d].size() != 0)
			begin
				head = exp_q[d][0];
				if (head[32+DW-1:DW] == edge_num)
				begin
					exp_valid[d] = 1'b1;
					exp_word[d]  = head[DW-1:0];
					void'(exp_q[d].pop_front());
				end
			end
		end
		check_value("o_node_valid", exp_valid, node_valid);
		for (int d = 0; d < NN; d++)
			check_value($sformatf("o_node_data[%0d]", d), exp_word[d],
				node_data[d*DW +: DW]);
		check_value("o_busy", m_busy, busy);
		check_value("assertion fail flags", '0, dut.u_sva.fail_flags);
	endtask

	// called on a falling edge and returns on the next one
	task automatic run_cycle(input logic v_en, input logic v_cmd,
		input dist_ctrl_pkg::opcode_t v_op, input dist_flit_pkg::data_t v_data,
		input dist_flit_pkg::dest_t v_dest, input dist_flit_pkg::mask_t v_mask);
		en        = v_en;
		cmd_valid = v_cmd;
		opcode    = v_op;
		data      = v_data;
		dest      = v_dest;
		mask      = v_mask;
		@(posedge CLK);
		model_step();
		@(negedge CLK);
		compare_outputs();
	endtask

	task automatic drain();
		repeat (DRAIN_CYCLES)
			run_cycle(1'b1, 1'b0, dist_ctrl_pkg::OP_NOP, '0, '0, '0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic                   cmd;
		logic                   run_en;
		logic                   empty_sent;
		dist_flit_pkg::mask_t   mc_mask;
		dist_ctrl_pkg::opcode_t op;
		int                     leftover;
		seed      = 34753;
		edge_num  = 0;
		m_busy    = 1'b0;
		m_rem     = '0;
		m_word    = '0;
		rst_n     = 1'b0;
		en        = 1'b0;
		cmd_valid = 1'b0;
		opcode    = dist_ctrl_pkg::OP_NOP;
		data      = '0;
		dest      = '0;
		mask      = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;

		// quiet network after reset
		repeat (IDLE_CYCLES)
			run_cycle(1'b1, 1'b0, dist_ctrl_pkg::OP_NOP, '0, '0, '0);

		// back-to-back unicasts fill the chain
		for (int i = 0; i < UNI_CYCLES; i++)
			run_cycle(1'b1, 1'b1, dist_ctrl_pkg::OP_UNICAST, payload_word(),
				target_node(), '0);
		drain();

		// multicasts with strobes that land while busy
		empty_sent = 1'b0;
		for (int i = 0; i < MC_CYCLES; i++)
		begin
			cmd     = (pick(4) != 0);
			mc_mask = dest_mask();
			if (i == 0)
			begin
				cmd     = 1'b1;
				mc_mask = '1;
			end
			else if (!empty_sent && !m_busy && i > 20)
			begin
				// empty mask while idle
				cmd        = 1'b1;
				mc_mask    = '0;
				empty_sent = 1'b1;
			end
			run_cycle(1'b1, cmd, dist_ctrl_pkg::OP_MULTICAST, payload_word(),
				target_node(), mc_mask);
		end
		drain();

		// mixed traffic with single-cycle enable drops
		for (int i = 0; i < MIX_CYCLES; i++)
		begin
			run_en = (pick(8) != 0) || !en;
			cmd    = (pick(2) != 0);
			case (pick(4))
				0: op = dist_ctrl_pkg::OP_NOP;
				3: op = dist_ctrl_pkg::OP_MULTICAST;
				default: op = dist_ctrl_pkg::OP_UNICAST;
			endcase
			run_cycle(run_en, cmd, op, payload_word(), target_node(), dest_mask());
		end
		drain();

		// nop strobes and then real commands with the network disabled
		for (int i = 0; i < NOP_CYCLES; i++)
		begin
			if (i % 2 == 0)
				run_cycle(1'b1, 1'b1, dist_ctrl_pkg::OP_NOP, payload_word(),
					target_node(), '1);
			else
			begin
				op = (pick(2) != 0) ? dist_ctrl_pkg::OP_UNICAST : dist_ctrl_pkg::OP_MULTICAST;
				run_cycle(1'b0, 1'b1, op, payload_word(), target_node(), '1);
			end
		end
		drain();

		leftover = 0;
		for (int d = 0; d < NN; d++)
			leftover = leftover + exp_q[d].size();
		if (leftover != 0 || m_busy)
		begin
			$display("ERROR: %0d expected deliveries never arrived", leftover);
			$display("TEST FAILED");
			$fatal(1, "undelivered flits");
		end
		else
		begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

//--- build.f
+incdir+verilog
verilog/dist_flit_pkg.sv
verilog/dist_ctrl_pkg.sv
verilog/dist_ingress.sv
verilog/dist_node_stage.sv
verilog/linear_unicast_chain.sv
verilog/dist_network_top.sv
tb/tb_clock_gen.sv
tb/dist_network_sva.sv
tb/dist_network_tb.sv
